// ==== Makefile ====
# Verilator lint and simulation for the ML-DSA-87 secret-key encoder.
# The simulator exits with a failing status when the testbench fails.

OBJ_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module skencode_top -f src.f

sim:
	verilator --binary --timing --top-module skencode_tb -f src.f \
		--Mdir $(OBJ_DIR) -o skencode_sim
	./$(OBJ_DIR)/skencode_sim

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+include
verilog/skenc_pkg.sv
verilog/eta_lane_encoder.sv
verilog/coeff_read_sequencer.sv
verilog/key_word_packer.sv
verilog/skencode_top.sv
verification/skencode_tb.sv

// ==== include/skencode_tb_tasks.svh ====
// Directed test tasks for the secret-key encoder testbench.
// Contains the value check, the reference eta-2 encoding and packing
// model, the coefficient fill, the host handshake helpers and one task
// per test.

`ifndef SKENCODE_TB_TASKS_SVH
`define SKENCODE_TB_TASKS_SVH

    // ========================================================================
    // Checks and reference model
    // ========================================================================
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual=0x%0h expected=0x%0h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // The code is 2 - c taken modulo q.
    function automatic logic [code_width-1:0] eta_code(input logic [coeff_width-1:0] c);
        int value;
        value = int'(c);
        if (value <= 2) begin
            return code_width'(2 - value);
        end
        return code_width'(q_mod + 2 - value);
    endfunction

    task automatic fill_coeffs(input logic [mem_addr_width-1:0] src);
        int pick;
        logic [coeff_width-1:0] value;
        for (int g = 0; g < coeff_total; g++) begin
            pick = int'({$random(seed)} % 5);
            case (pick)
                0: value = 24'd0;
                1: value = 24'd1;
                2: value = 24'd2;
                3: value = coeff_width'(q_mod - 1);
                default: value = coeff_width'(q_mod - 2);
            endcase
            coeff_mem[mem_addr_width'(int'(src) + g / 4)][coeff_width*(g%4) +: coeff_width] = value;
        end
    endtask

    // Coefficients in address order form the stream, three bits each, LSB first.
    task automatic build_reference(input logic [mem_addr_width-1:0] src);
        logic [coeff_width-1:0] c;
        for (int g = 0; g < coeff_total; g++) begin
            c = coeff_mem[mem_addr_width'(int'(src) + g / 4)][coeff_width*(g%4) +: coeff_width];
            stream_bits[code_width*g +: code_width] = eta_code(c);
        end
        for (int w = 0; w < key_word_count; w++) begin
            exp_words[w] = stream_bits[key_data_width*w +: key_data_width];
        end
    endtask

    task automatic set_latency(input logic random_lat);
        for (int j = 0; j < read_pair_count; j++) begin
            lat_extra[j] = random_lat ? int'({$random(seed)} % 3) : 0;
        end
    endtask

    // ========================================================================
    // Handshake helpers
    // ========================================================================
    task automatic start_run(input logic [mem_addr_width-1:0] src,
                             input logic [mem_addr_width-1:0] dst);
        @(posedge clk);
        src_base <= src;
        dest_base <= dst;
        enc_req <= 1'b1;
    endtask

    // Error must not show up before the ack does.
    task automatic wait_ack();
        @(posedge clk);
        while (enc_ack !== 1'b1) begin
            check_value("enc_error", 64'(enc_error), 64'd0);
            @(posedge clk);
        end
    endtask

    task automatic finish_run(input logic expect_error);
        check_value("enc_error", 64'(enc_error), 64'(expect_error));
        repeat (3) begin
            @(posedge clk);
            check_value("enc_ack", 64'(enc_ack), 64'd1);
        end
        enc_req <= 1'b0;
        @(posedge clk);
        check_value("enc_ack", 64'(enc_ack), 64'd1);
        @(posedge clk);
        check_value("enc_ack", 64'(enc_ack), 64'd0);
        check_value("enc_error", 64'(enc_error), 64'd0);
    endtask

    task automatic check_writes(input logic [mem_addr_width-1:0] dst, input int first,
                                input int count);
        logic [mem_addr_width-1:0] addr;
        check_value("key write count", 64'(wr_addr_q.size() - first), 64'(count));
        for (int w = 0; w < count; w++) begin
            addr = mem_addr_width'(int'(dst) + w);
            check_value("key_wr_addr", 64'(wr_addr_q[first + w]), 64'(addr));
            check_value("key_wr_data", 64'(key_mem[addr]), 64'(exp_words[w]));
        end
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic idle_after_reset();
        repeat (10) begin
            @(posedge clk);
            check_value("enc_ack", 64'(enc_ack), 64'd0);
            check_value("enc_error", 64'(enc_error), 64'd0);
            check_value("key_wr_en", 64'(key_wr_en), 64'd0);
            check_value("mem_a_rd_en", 64'(mem_a_rd_en), 64'd0);
            check_value("mem_b_rd_en", 64'(mem_b_rd_en), 64'd0);
        end
    endtask

    task automatic encode_clean_run(input logic [mem_addr_width-1:0] src,
                                    input logic [mem_addr_width-1:0] dst,
                                    input logic random_lat);
        int first_wr;
        int first_rd;
        set_latency(random_lat);
        fill_coeffs(src);
        build_reference(src);
        first_wr = wr_addr_q.size();
        first_rd = rd_total;
        start_run(src, dst);
        wait_ack();
        finish_run(1'b0);
        check_value("read pair count", 64'(rd_total - first_rd), 64'(read_pair_count));
        check_writes(dst, first_wr, key_word_count);
    endtask

    // Only words that end before the bad coefficient's group get written.
    task automatic encode_bad_coeff(input logic [mem_addr_width-1:0] src,
                                    input logic [mem_addr_width-1:0] dst);
        int bad_index;
        int good_words;
        int first_wr;
        set_latency(1'b0);
        fill_coeffs(src);
        bad_index = int'({$random(seed)} % coeff_total);
        coeff_mem[mem_addr_width'(int'(src) + bad_index / 4)][coeff_width*(bad_index%4) +:
            coeff_width] = 24'd3;
        build_reference(src);
        good_words = (bad_index / lane_count) * group_width / key_data_width;
        first_wr = wr_addr_q.size();
        start_run(src, dst);
        wait_ack();
        finish_run(1'b1);
        repeat (5) @(posedge clk);
        check_writes(dst, first_wr, good_words);
    endtask

    task automatic zeroize_mid_run(input logic [mem_addr_width-1:0] src,
                                   input logic [mem_addr_width-1:0] dst);
        int first_wr;
        set_latency(1'b0);
        fill_coeffs(src);
        first_wr = wr_addr_q.size();
        start_run(src, dst);
        while (wr_addr_q.size() - first_wr < 100) begin
            @(posedge clk);
        end
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        enc_req <= 1'b0;
        @(posedge clk);
        repeat (20) begin
            @(posedge clk);
            check_value("key_wr_en", 64'(key_wr_en), 64'd0);
            check_value("mem_a_rd_en", 64'(mem_a_rd_en), 64'd0);
            check_value("mem_b_rd_en", 64'(mem_b_rd_en), 64'd0);
            check_value("enc_ack", 64'(enc_ack), 64'd0);
        end
        encode_clean_run(src, dst, 1'b0);
    endtask

`endif

// ==== verification/skencode_tb.sv ====
// Testbench for the ML-DSA-87 secret-key encoder.
// Contains the clock and reset, the coefficient memory model with in-order
// variable latency, the key memory model, the DUT, the cycle timeout and
// the directed test sequence.

module skencode_tb;

    import skenc_pkg::*;

    localparam int coeff_total = read_pair_count * lane_count;
    localparam int q_mod = 8380417;
    // Six runs of a little over read_pair_count cycles each, doubled for margin.
    localparam int run_cycles = read_pair_count + 20;
    localparam int timeout_cycles = 2 * 6 * run_cycles;

    logic                                   clk = 1'b0;
    logic                                   reset_n;
    logic                                   zeroize;
    logic                                   enc_req;
    logic [mem_addr_width-1:0]              src_base;
    logic [mem_addr_width-1:0]              dest_base;
    logic                                   enc_ack;
    logic                                   enc_error;
    logic                                   mem_a_rd_en;
    logic [mem_addr_width-1:0]              mem_a_rd_addr;
    logic                                   mem_b_rd_en;
    logic [mem_addr_width-1:0]              mem_b_rd_addr;
    logic [coeffs_per_word*coeff_width-1:0] mem_a_rd_data = '0;
    logic [coeffs_per_word*coeff_width-1:0] mem_b_rd_data = '0;
    logic                                   mem_rd_valid = 1'b0;
    logic                                   key_wr_en;
    logic [mem_addr_width-1:0]              key_wr_addr;
    logic [key_data_width-1:0]              key_wr_data;

    // Memory models, pending read responses and reference data.
    logic [coeffs_per_word*coeff_width-1:0] coeff_mem [0:(1<<mem_addr_width)-1];
    logic [key_data_width-1:0]              key_mem [0:(1<<mem_addr_width)-1];
    logic [mem_addr_width-1:0]              wr_addr_q [$];
    logic [mem_addr_width-1:0]              pend_addr_q [$];
    int                                     pend_due_q [$];
    int                                     lat_extra [0:read_pair_count-1];
    logic [coeff_total*code_width-1:0]      stream_bits;
    logic [key_data_width-1:0]              exp_words [0:key_word_count-1];
    logic [mem_addr_width-1:0]              resp_addr;
    int                                     rd_pairs = 0;
    int                                     rd_total = 0;
    int                                     due_cycle = 0;
    int                                     last_due = -1;
    int                                     cycle_count = 0;
    integer                                 seed = 86;

    skencode_top skencode_top_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .enc_req       (enc_req),
        .src_base      (src_base),
        .dest_base     (dest_base),
        .enc_ack       (enc_ack),
        .enc_error     (enc_error),
        .mem_a_rd_en   (mem_a_rd_en),
        .mem_a_rd_addr (mem_a_rd_addr),
        .mem_b_rd_en   (mem_b_rd_en),
        .mem_b_rd_addr (mem_b_rd_addr),
        .mem_a_rd_data (mem_a_rd_data),
        .mem_b_rd_data (mem_b_rd_data),
        .mem_rd_valid  (mem_rd_valid),
        .key_wr_en     (key_wr_en),
        .key_wr_addr   (key_wr_addr),
        .key_wr_data   (key_wr_data)
    );

    `include "skencode_tb_tasks.svh"

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    // ========================================================================
    // Coefficient memory
    // ========================================================================
    // A request seen at this edge is answered at the edge given by its due
    // cycle. Due cycles only grow, so answers stay in request order.
    always @(posedge clk) begin
        if (mem_a_rd_en || mem_b_rd_en) begin
            // Reads are always issued as a pair.
            check_value("mem_a_rd_en", 64'(mem_a_rd_en), 64'd1);
            check_value("mem_b_rd_en", 64'(mem_b_rd_en), 64'd1);
            check_value("mem_a_rd_addr", 64'(mem_a_rd_addr),
                64'(mem_addr_width'(int'(src_base) + 2 * rd_pairs)));
            check_value("mem_b_rd_addr", 64'(mem_b_rd_addr),
                64'(mem_addr_width'(int'(src_base) + 2 * rd_pairs + 1)));
            due_cycle = cycle_count + lat_extra[rd_pairs % read_pair_count];
            if (due_cycle <= last_due) begin
                due_cycle = last_due + 1;
            end
            last_due = due_cycle;
            pend_addr_q.push_back(mem_a_rd_addr);
            pend_due_q.push_back(due_cycle);
            rd_pairs = rd_pairs + 1;
            rd_total = rd_total + 1;
        end else begin
            rd_pairs = 0;
        end
        if (pend_due_q.size() > 0 && pend_due_q[0] == cycle_count) begin
            resp_addr = pend_addr_q.pop_front();
            void'(pend_due_q.pop_front());
            mem_a_rd_data <= coeff_mem[resp_addr];
            mem_b_rd_data <= coeff_mem[resp_addr + 1'b1];
            mem_rd_valid <= 1'b1;
        end else begin
            mem_rd_valid <= 1'b0;
        end
    end

    // Key memory keeps the data and the order of write addresses.
    always @(posedge clk) begin
        if (key_wr_en) begin
            key_mem[key_wr_addr] <= key_wr_data;
            wr_addr_q.push_back(key_wr_addr);
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        reset_n = 1'b0;
        zeroize = 1'b0;
        enc_req = 1'b0;
        src_base = '0;
        dest_base = '0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        idle_after_reset();
        encode_clean_run(15'h0000, 15'h0000, 1'b0);
        encode_clean_run(15'h1234, 15'h4a00, 1'b1);
        encode_bad_coeff(15'h2000, 15'h5000);
        encode_clean_run(15'h2000, 15'h5800, 1'b0);
        zeroize_mid_run(15'h0800, 15'h6000);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog/coeff_read_sequencer.sv ====
// Read sequencer for the secret-key encoder.
// Contains the host req/ack handshake, the base-address capture, the
// dual read-request generation and the completion and abort control.

module coeff_read_sequencer (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize,
    input  logic                                enc_req,
    input  logic [skenc_pkg::mem_addr_width-1:0] src_base,
    input  logic [skenc_pkg::mem_addr_width-1:0] dest_base,
    output logic                                enc_ack,
    output logic                                enc_error,
    output logic                                mem_a_rd_en,
    output logic                                mem_b_rd_en,
    output logic [skenc_pkg::mem_addr_width-1:0] mem_a_rd_addr,
    output logic [skenc_pkg::mem_addr_width-1:0] mem_b_rd_addr,
    output logic                                pack_start,
    output logic [skenc_pkg::mem_addr_width-1:0] pack_dest_base,
    input  logic                                pack_abort,
    input  logic                                pack_done
);

    import skenc_pkg::*;

    typedef enum logic [1:0] {
        seq_idle,
        seq_read,
        seq_drain,
        seq_ack
    } seq_state_t;

    seq_state_t                state;
    logic [pair_cnt_width-1:0] pair_cnt;
    logic [mem_addr_width-1:0] src_q;
    logic [mem_addr_width-1:0] dest_q;
    logic [mem_addr_width-1:0] pair_offset;
    logic                      reads_on;

    // ========================================================================
    // Control FSM
    // ========================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= seq_idle;
            pair_cnt <= '0;
            enc_ack <= 1'b0;
            enc_error <= 1'b0;
            pack_start <= 1'b0;
        end else if (zeroize) begin
            state <= seq_idle;
            pair_cnt <= '0;
            enc_ack <= 1'b0;
            enc_error <= 1'b0;
            pack_start <= 1'b0;
        end else begin
            pack_start <= 1'b0;
            case (state)
                seq_idle: begin
                    if (enc_req) begin
                        state <= seq_read;
                        pair_cnt <= '0;
                        pack_start <= 1'b1;
                    end
                end
                seq_read: begin
                    if (pack_abort) begin
                        state <= seq_ack;
                        enc_ack <= 1'b1;
                        enc_error <= 1'b1;
                    end else begin
                        pair_cnt <= pair_cnt + 1'b1;
                        if (pair_cnt == pair_cnt_width'(read_pair_count - 1)) begin
                            state <= seq_drain;
                        end
                    end
                end
                seq_drain: begin
                    // Late responses are still being packed here.
                    if (pack_abort) begin
                        state <= seq_ack;
                        enc_ack <= 1'b1;
                        enc_error <= 1'b1;
                    end else if (pack_done) begin
                        state <= seq_ack;
                        enc_ack <= 1'b1;
                    end
                end
                default: begin
                    // Hold the ack until the host releases its request.
                    if (!enc_req) begin
                        state <= seq_idle;
                        enc_ack <= 1'b0;
                        enc_error <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Bases are sampled once per run.
    always_ff @(posedge clk) begin
        if (zeroize) begin
            src_q <= '0;
            dest_q <= '0;
        end else if (state == seq_idle && enc_req) begin
            src_q <= src_base;
            dest_q <= dest_base;
        end
    end

    // ========================================================================
    // Read requests
    // ========================================================================
    // An abort cuts the read stream in the same cycle.
    assign reads_on = (state == seq_read) && !pack_abort;
    assign pair_offset = mem_addr_width'({pair_cnt, 1'b0});

    assign mem_a_rd_en = reads_on;
    assign mem_b_rd_en = reads_on;
    assign mem_a_rd_addr = src_q + pair_offset;
    assign mem_b_rd_addr = src_q + pair_offset + 1'b1;
    assign pack_dest_base = dest_q;

endmodule

// ==== verilog/eta_lane_encoder.sv ====
// Single eta-2 lane encoder.
// Maps one stored coefficient to its 3-bit code and flags values that
// lie outside the eta range.

module eta_lane_encoder (
    input  logic [skenc_pkg::coeff_width-1:0] coeff,
    output logic [skenc_pkg::code_width-1:0]  code,
    output logic                              bad_coeff
);

    import skenc_pkg::*;

    // Only five coefficient values are legal for eta 2.
    always_comb begin
        code = '0;
        bad_coeff = 1'b0;
        case (coeff)
            coeff_width'(0): code = code_for_zero;
            coeff_width'(1): code = code_for_one;
            coeff_width'(2): code = code_for_two;
            coeff_minus_one: code = code_for_minus_one;
            coeff_minus_two: code = code_for_minus_two;
            default: begin
                // The packer aborts the run on an out-of-range value.
                bad_coeff = 1'b1;
            end
        endcase
    end

endmodule

// ==== verilog/key_word_packer.sv ====
// Key-word packer for the secret-key encoder.
// Appends 24-bit code groups to a bit-stream accumulator, writes 32-bit
// words to key memory, counts the writes and detects groups with a bad
// coefficient.

module key_word_packer (
    input  logic                                            clk,
    input  logic                                            reset_n,
    input  logic                                            zeroize,
    input  logic                                            pack_start,
    input  logic [skenc_pkg::mem_addr_width-1:0]            pack_dest_base,
    input  logic                                            mem_rd_valid,
    input  logic [skenc_pkg::lane_count*skenc_pkg::code_width-1:0] lane_codes,
    input  logic [skenc_pkg::lane_count-1:0]                lane_errors,
    output logic                                            pack_abort,
    output logic                                            pack_done,
    output logic                                            key_wr_en,
    output logic [skenc_pkg::mem_addr_width-1:0]            key_wr_addr,
    output logic [skenc_pkg::key_data_width-1:0]            key_wr_data
);

    import skenc_pkg::*;

    logic                      active;
    logic [acc_width-1:0]      acc;
    logic [acc_cnt_width-1:0]  acc_bits;
    logic [word_cnt_width-1:0] word_cnt;
    logic [mem_addr_width-1:0] base_q;
    logic [acc_width-1:0]      merged;
    logic [acc_cnt_width-1:0]  merged_bits;
    logic                      group_bad;
    logic                      take_group;
    logic                      word_ready;
    logic                      last_word;

    // ========================================================================
    // Stream merge
    // ========================================================================
    // The new group lands just above the bits already held. At most 31 bits
    // are held between cycles, so one word out per cycle keeps up.
    assign group_bad = mem_rd_valid && active && (|lane_errors);
    assign take_group = mem_rd_valid && active && !(|lane_errors);
    assign merged = acc | (acc_width'(lane_codes) << acc_bits);
    assign merged_bits = acc_bits + acc_cnt_width'(group_width);
    assign word_ready = take_group && (merged_bits >= acc_cnt_width'(key_data_width));
    assign last_word = word_ready && (word_cnt == word_cnt_width'(key_word_count - 1));

    // ========================================================================
    // Control
    // ========================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active <= 1'b0;
            acc_bits <= '0;
            word_cnt <= '0;
            key_wr_en <= 1'b0;
            pack_abort <= 1'b0;
            pack_done <= 1'b0;
        end else if (zeroize) begin
            active <= 1'b0;
            acc_bits <= '0;
            word_cnt <= '0;
            key_wr_en <= 1'b0;
            pack_abort <= 1'b0;
            pack_done <= 1'b0;
        end else begin
            key_wr_en <= word_ready;
            pack_done <= last_word;
            pack_abort <= group_bad;
            if (pack_start) begin
                active <= 1'b1;
                acc_bits <= '0;
                word_cnt <= '0;
            end else begin
                // A bad group or the final word ends the run.
                if (group_bad || last_word) begin
                    active <= 1'b0;
                end
                if (take_group) begin
                    if (word_ready) begin
                        acc_bits <= merged_bits - acc_cnt_width'(key_data_width);
                    end else begin
                        acc_bits <= merged_bits;
                    end
                end
                if (word_ready) begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // Accumulator and write data.
    always_ff @(posedge clk) begin
        if (zeroize) begin
            acc <= '0;
            base_q <= '0;
            key_wr_addr <= '0;
            key_wr_data <= '0;
        end else begin
            if (pack_start) begin
                acc <= '0;
                base_q <= pack_dest_base;
            end else if (take_group) begin
                if (word_ready) begin
                    acc <= merged >> key_data_width;
                end else begin
                    acc <= merged;
                end
            end
            if (word_ready) begin
                key_wr_data <= merged[key_data_width-1:0];
                key_wr_addr <= base_q + mem_addr_width'(word_cnt);
            end
        end
    end

endmodule

// ==== verilog/skenc_pkg.sv ====
// Shared constants for the ML-DSA-87 secret-key encoder.
// Holds the ML-DSA sizes, the eta-2 code values and the derived counts
// and widths used by the sequencer, the lanes and the packer.

package skenc_pkg;

    // ========================================================================
    // ML-DSA-87 sizes
    // ========================================================================
    localparam logic [22:0] mldsa_q = 23'd8380417;
    localparam int mldsa_n = 256;
    localparam int mldsa_k = 8;
    localparam int mldsa_l = 7;

    localparam int coeff_width = 24;
    localparam int code_width = 3;
    localparam int lane_count = 8;
    localparam int coeffs_per_word = lane_count / 2;
    localparam int mem_addr_width = 15;
    localparam int key_data_width = 32;

    // Codes are 2 - c mod q for c in {0, 1, 2, q-1, q-2}.
    localparam logic [coeff_width-1:0] coeff_minus_one = coeff_width'(mldsa_q - 23'd1);
    localparam logic [coeff_width-1:0] coeff_minus_two = coeff_width'(mldsa_q - 23'd2);
    localparam logic [code_width-1:0] code_for_zero = 3'd2;
    localparam logic [code_width-1:0] code_for_one = 3'd1;
    localparam logic [code_width-1:0] code_for_two = 3'd0;
    localparam logic [code_width-1:0] code_for_minus_one = 3'd3;
    localparam logic [code_width-1:0] code_for_minus_two = 3'd4;

    // ========================================================================
    // Derived counts and widths
    // ========================================================================
    localparam int group_width = lane_count * code_width;
    localparam int read_pair_count = (mldsa_k + mldsa_l) * mldsa_n / lane_count;
    localparam int key_word_count = (mldsa_k + mldsa_l) * mldsa_n * code_width / key_data_width;
    localparam int acc_width = key_data_width - 1 + group_width;
    localparam int acc_cnt_width = $clog2(acc_width + 1);
    localparam int pair_cnt_width = $clog2(read_pair_count);
    localparam int word_cnt_width = $clog2(key_word_count);

endpackage

// ==== verilog/skencode_top.sv ====
// Top level of the ML-DSA-87 secret-key encoder.
// Holds the read sequencer, eight eta lane encoders and the key-word
// packer, with the wiring between them.

module skencode_top (
    input  logic                                                   clk,
    input  logic                                                   reset_n,
    input  logic                                                   zeroize,
    input  logic                                                   enc_req,
    input  logic [skenc_pkg::mem_addr_width-1:0]                   src_base,
    input  logic [skenc_pkg::mem_addr_width-1:0]                   dest_base,
    output logic                                                   enc_ack,
    output logic                                                   enc_error,
    output logic                                                   mem_a_rd_en,
    output logic [skenc_pkg::mem_addr_width-1:0]                   mem_a_rd_addr,
    output logic                                                   mem_b_rd_en,
    output logic [skenc_pkg::mem_addr_width-1:0]                   mem_b_rd_addr,
    input  logic [skenc_pkg::coeffs_per_word*skenc_pkg::coeff_width-1:0] mem_a_rd_data,
    input  logic [skenc_pkg::coeffs_per_word*skenc_pkg::coeff_width-1:0] mem_b_rd_data,
    input  logic                                                   mem_rd_valid,
    output logic                                                   key_wr_en,
    output logic [skenc_pkg::mem_addr_width-1:0]                   key_wr_addr,
    output logic [skenc_pkg::key_data_width-1:0]                   key_wr_data
);

    import skenc_pkg::*;

    logic                               pack_start;
    logic [mem_addr_width-1:0]          pack_dest_base;
    logic                               pack_abort;
    logic                               pack_done;
    logic [lane_count*coeff_width-1:0]  all_coeffs;
    logic [lane_count*code_width-1:0]   lane_codes;
    logic [lane_count-1:0]              lane_errors;

    coeff_read_sequencer coeff_read_sequencer_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enc_req        (enc_req),
        .src_base       (src_base),
        .dest_base      (dest_base),
        .enc_ack        (enc_ack),
        .enc_error      (enc_error),
        .mem_a_rd_en    (mem_a_rd_en),
        .mem_b_rd_en    (mem_b_rd_en),
        .mem_a_rd_addr  (mem_a_rd_addr),
        .mem_b_rd_addr  (mem_b_rd_addr),
        .pack_start     (pack_start),
        .pack_dest_base (pack_dest_base),
        .pack_abort     (pack_abort),
        .pack_done      (pack_done)
    );

    // Port a feeds lanes 0 to 3, port b feeds lanes 4 to 7.
    assign all_coeffs = {mem_b_rd_data, mem_a_rd_data};

    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        eta_lane_encoder eta_lane_encoder_inst (
            .coeff     (all_coeffs[i*coeff_width +: coeff_width]),
            .code      (lane_codes[i*code_width +: code_width]),
            .bad_coeff (lane_errors[i])
        );
    end

    key_word_packer key_word_packer_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .pack_start     (pack_start),
        .pack_dest_base (pack_dest_base),
        .mem_rd_valid   (mem_rd_valid),
        .lane_codes     (lane_codes),
        .lane_errors    (lane_errors),
        .pack_abort     (pack_abort),
        .pack_done      (pack_done),
        .key_wr_en      (key_wr_en),
        .key_wr_addr    (key_wr_addr),
        .key_wr_data    (key_wr_data)
    );

endmodule
